//--- flist.f
+incdir+tests
src/arrayGeometryPkg.sv
src/arrayOpsPkg.sv
src/requestStage.sv
src/arrayAllocator.sv
src/arrayStore.sv
src/responseQueue.sv
src/arrayMemory.sv
tests/arrayMemoryTb.sv

//--- run.sh
#!/bin/sh
# Build and run the array memory testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module arrayMemoryTb -o arrayMemorySim \
  && ./obj_dir/arrayMemorySim > sim.log 2>&1 \
  || { echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "^TEST OK$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- src/arrayAllocator.sv
//----------------------------------------
// Array allocator with live flags, a
// stack of released arrays and a
// fresh-array counter
//----------------------------------------
module arrayAllocator (
  input  logic                        clock,
  input  logic                        resetN,
  input  logic                        grant,
  input  logic                        releaseEn,
  input  arrayGeometryPkg::arrayNumT  releaseArray,
  output arrayGeometryPkg::liveMaskT  liveMask,
  output arrayGeometryPkg::arrayNumT  nextFree,
  output logic                        poolEmpty
);
  import arrayGeometryPkg::*;

  localparam logic [arrayBits:0] allArrays = (arrayBits + 1)'(arrayCount);

  arrayNumT             freeStack [arrayCount];  // Released arrays with the newest on top
  logic [arrayBits:0]   stackDepth;
  logic [arrayBits:0]   freshCount;              // Arrays handed out from new
  arrayNumT             topIndex;

  assign topIndex  = arrayNumT'(stackDepth - 1'b1);
  assign nextFree  = (stackDepth != '0) ? freeStack[topIndex]
                                        : freshCount[arrayBits-1:0];
  assign poolEmpty = (stackDepth == '0) && (freshCount == allArrays);

  //----------------------------------------
  // Control state
  //----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      liveMask   <= '0;
      stackDepth <= '0;
      freshCount <= '0;
    end else if (grant) begin
      liveMask[nextFree] <= 1'b1;
      if (stackDepth != '0) begin
        stackDepth <= stackDepth - 1'b1;         // Reuse before fresh
      end else begin
        freshCount <= freshCount + 1'b1;
      end
    end else if (releaseEn) begin
      liveMask[releaseArray] <= 1'b0;
      stackDepth             <= stackDepth + 1'b1;
    end
  end

  // Stack contents
  always_ff @(posedge clock) begin
    if (releaseEn && !grant) begin
      freeStack[stackDepth[arrayBits-1:0]] <= releaseArray;
    end
  end

endmodule

//--- src/arrayGeometryPkg.sv
//----------------------------------------
// Array bank geometry: bit widths, array
// and element counts, vector typedefs
//----------------------------------------
package arrayGeometryPkg;

  // Widths
  localparam int arrayBits = 3;                  // Bits of an array number
  localparam int indexBits = 3;                  // Bits of an element index
  localparam int dataBits  = 16;                 // Element width

  // Counts
  localparam int arrayCount  = 8;                // Arrays in the bank
  localparam int arrayLength = 8;                // Elements per array

  //----------------------------------------
  // Vector types
  //----------------------------------------
  typedef logic [arrayBits-1:0]  arrayNumT;      // One array
  typedef logic [indexBits-1:0]  elemIndexT;     // One element position
  typedef logic [indexBits:0]    sizeT;          // Size 0 to arrayLength
  typedef logic [dataBits-1:0]   dataT;          // Element or result value
  typedef logic [arrayCount-1:0] liveMaskT;      // Allocation flag per array

endpackage

//--- src/arrayMemory.sv
//----------------------------------------
// Array memory unit top level
//----------------------------------------
module arrayMemory (
  input  logic                     clock,
  input  logic                     resetN,
  input  logic                     reqValid,
  output logic                     reqReady,
  input  arrayOpsPkg::memRequestT  req,
  output logic                     respValid,
  output arrayOpsPkg::memResponseT resp,
  input  logic                     respReady
);
  import arrayGeometryPkg::*;
  import arrayOpsPkg::*;

  logic        queueSpace;
  logic        execValid;
  memRequestT  execReq;
  memResponseT execResp;                         // Pushed on execValid
  liveMaskT    liveMask;
  arrayNumT    nextFree;
  logic        poolEmpty;
  logic        grant;
  logic        releaseEn;
  arrayNumT    releaseArray;

  // Input side
  requestStage i_requestStage (
    .clock, .resetN, .reqValid, .reqReady, .req,
    .queueSpace, .execValid, .execReq
  );

  // Processing part
  arrayAllocator i_arrayAllocator (
    .clock, .resetN, .grant, .releaseEn, .releaseArray,
    .liveMask, .nextFree, .poolEmpty
  );

  arrayStore i_arrayStore (
    .clock, .resetN, .execValid, .execReq, .liveMask, .nextFree, .poolEmpty,
    .grant, .releaseEn, .releaseArray, .resp(execResp)
  );

  // Output side
  responseQueue i_responseQueue (
    .clock, .resetN, .push(execValid), .pushData(execResp),
    .queueSpace, .respValid, .resp, .respReady
  );

endmodule

//--- src/arrayOpsPkg.sv
//----------------------------------------
// Operation encodings: opcode and error
// enums, request and response structs
//----------------------------------------
package arrayOpsPkg;
  import arrayGeometryPkg::*;

  //----------------------------------------
  // Opcodes
  //----------------------------------------
  typedef enum logic [4:0] {
    alloc,                                       // Hand out a free array
    releaseOp,                                   // Return an array to the pool
    write,                                       // Store element, may grow size
    read,                                        // Fetch element
    size,                                        // Current array size
    push,                                        // Append at the end
    pop,                                         // Remove from the end
    findIndex,                                   // One plus last matching position
    countLess,                                   // Elements below operand
    countGreater,                                // Elements above operand
    add,                                         // Returns new value
    addAfter,                                    // Returns previous value
    subtract,                                    // Returns new value
    subAfter,                                    // Returns previous value
    andOp,
    orOp,
    xorOp
  } opcodeT;

  // Error codes carried on each response
  typedef enum logic [2:0] {
    noError,
    notAllocated,                                // Array is not live
    outOfBounds,                                 // Index at or past size
    arrayFull,                                   // Push at full size
    arrayEmpty,                                  // Pop at size zero
    noFreeArray                                  // Pool exhausted
  } errorT;

  //----------------------------------------
  // Channel payloads
  //----------------------------------------
  typedef struct packed {
    opcodeT    opcode;
    arrayNumT  array;                            // Target array
    elemIndexT index;                            // Element position
    dataT      operand;                          // Value for write, push, search, update
  } memRequestT;

  typedef struct packed {
    dataT  result;                               // Zero on error
    errorT error;
  } memResponseT;

endpackage

//--- src/arrayStore.sv
//----------------------------------------
// Element memory and array sizes, with
// checks and execution of all operations
//----------------------------------------
module arrayStore (
  input  logic                        clock,
  input  logic                        resetN,
  input  logic                        execValid,
  input  arrayOpsPkg::memRequestT     execReq,
  input  arrayGeometryPkg::liveMaskT  liveMask,
  input  arrayGeometryPkg::arrayNumT  nextFree,
  input  logic                        poolEmpty,
  output logic                        grant,
  output logic                        releaseEn,
  output arrayGeometryPkg::arrayNumT  releaseArray,
  output arrayOpsPkg::memResponseT    resp
);
  import arrayGeometryPkg::*;
  import arrayOpsPkg::*;

  localparam sizeT fullSize = sizeT'(arrayLength);

  dataT      elements   [arrayCount][arrayLength];
  sizeT      arraySizes [arrayCount];

  sizeT      curSize;
  dataT      curElem;                            // Element at request index
  dataT      lastElem;                           // Element at size minus one
  dataT      updValue;                           // Element op operand
  sizeT      foundIndex;
  sizeT      lessCount;
  sizeT      greaterCount;
  logic      inBounds;

  // Decisions of the current request
  logic      doWrite;
  elemIndexT writeIdx;
  dataT      writeData;
  logic      doSize;
  arrayNumT  sizeArray;
  sizeT      newSize;
  logic      doGrant;
  logic      doRelease;

  assign curSize  = arraySizes[execReq.array];
  assign curElem  = elements[execReq.array][execReq.index];
  assign lastElem = elements[execReq.array][elemIndexT'(curSize - 1'b1)];
  assign inBounds = sizeT'(execReq.index) < curSize;

  //----------------------------------------
  // Searches over the live part
  //----------------------------------------
  always_comb begin
    foundIndex   = '0;
    lessCount    = '0;
    greaterCount = '0;
    for (int i = 0; i < arrayLength; i++) begin
      if (sizeT'(i) < curSize) begin
        if (elements[execReq.array][i] == execReq.operand) begin
          foundIndex = sizeT'(i + 1);            // Highest match wins
        end
        if (elements[execReq.array][i] < execReq.operand) begin
          lessCount = lessCount + 1'b1;
        end
        if (elements[execReq.array][i] > execReq.operand) begin
          greaterCount = greaterCount + 1'b1;
        end
      end
    end
  end

  // Read-modify-write value, wraps at 16 bits
  always_comb begin
    case (execReq.opcode)
      add, addAfter:      updValue = curElem + execReq.operand;
      subtract, subAfter: updValue = curElem - execReq.operand;
      andOp:              updValue = curElem & execReq.operand;
      orOp:               updValue = curElem | execReq.operand;
      xorOp:              updValue = curElem ^ execReq.operand;
      default:            updValue = curElem;
    endcase
  end

  //----------------------------------------
  // Checks, result and state decisions
  //----------------------------------------
  always_comb begin
    resp.result = '0;
    resp.error  = noError;
    doWrite     = 1'b0;
    writeIdx    = execReq.index;
    writeData   = execReq.operand;
    doSize      = 1'b0;
    sizeArray   = execReq.array;
    newSize     = curSize;
    doGrant     = 1'b0;
    doRelease   = 1'b0;

    if (execReq.opcode == alloc) begin
      if (poolEmpty) begin
        resp.error = noFreeArray;
      end else begin
        resp.result = dataT'(nextFree);
        doGrant     = 1'b1;
        doSize      = 1'b1;
        sizeArray   = nextFree;                  // Fresh array starts empty
        newSize     = '0;
      end
    end else if (!liveMask[execReq.array]) begin
      resp.error = notAllocated;
    end else begin
      case (execReq.opcode)
        releaseOp: doRelease = 1'b1;
        write: begin
          doWrite     = 1'b1;
          resp.result = execReq.operand;
          if (sizeT'(execReq.index) >= curSize) begin
            doSize  = 1'b1;
            newSize = sizeT'(execReq.index) + 1'b1;
          end
        end
        read: begin
          if (!inBounds) resp.error = outOfBounds;
          else           resp.result = curElem;
        end
        size: resp.result = dataT'(curSize);
        push: begin
          if (curSize == fullSize) begin
            resp.error = arrayFull;
          end else begin
            doWrite     = 1'b1;
            writeIdx    = elemIndexT'(curSize);  // Slot just past the end
            doSize      = 1'b1;
            newSize     = curSize + 1'b1;
            resp.result = execReq.operand;
          end
        end
        pop: begin
          if (curSize == '0) begin
            resp.error = arrayEmpty;
          end else begin
            doSize      = 1'b1;
            newSize     = curSize - 1'b1;
            resp.result = lastElem;
          end
        end
        findIndex:    resp.result = dataT'(foundIndex);
        countLess:    resp.result = dataT'(lessCount);
        countGreater: resp.result = dataT'(greaterCount);
        add, addAfter, subtract, subAfter, andOp, orOp, xorOp: begin
          if (!inBounds) begin
            resp.error = outOfBounds;
          end else begin
            doWrite   = 1'b1;
            writeData = updValue;
            if (execReq.opcode == addAfter || execReq.opcode == subAfter) begin
              resp.result = curElem;             // Value before the update
            end else begin
              resp.result = updValue;
            end
          end
        end
        default: resp.result = '0;
      endcase
    end
  end

  assign grant        = execValid && doGrant;
  assign releaseEn    = execValid && doRelease;
  assign releaseArray = execReq.array;

  //----------------------------------------
  // State update
  //----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < arrayCount; a++) begin
        arraySizes[a] <= '0;
      end
    end else if (execValid && doSize) begin
      arraySizes[sizeArray] <= newSize;
    end
  end

  always_ff @(posedge clock) begin
    if (execValid && doWrite) begin
      elements[execReq.array][writeIdx] <= writeData;
    end
  end

endmodule

//--- src/requestStage.sv
//----------------------------------------
// Request holding register with staged
// flag and request handshake
//----------------------------------------
module requestStage (
  input  logic                    clock,
  input  logic                    resetN,
  input  logic                    reqValid,
  output logic                    reqReady,
  input  arrayOpsPkg::memRequestT req,
  input  logic                    queueSpace,
  output logic                    execValid,
  output arrayOpsPkg::memRequestT execReq
);
  import arrayOpsPkg::*;

  logic       staged;                            // Holding register is full
  memRequestT heldReq;

  assign execValid = staged && queueSpace;       // Runs only if the response fits
  assign reqReady  = !staged || execValid;       // Empty or emptying this cycle
  assign execReq   = heldReq;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      staged <= 1'b0;
    end else if (reqValid && reqReady) begin
      staged <= 1'b1;                            // Replaces the one leaving, if any
    end else if (execValid) begin
      staged <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reqValid && reqReady) begin
      heldReq <= req;
    end
  end

endmodule

//--- src/responseQueue.sv
//----------------------------------------
// Two-entry in-order response FIFO
//----------------------------------------
module responseQueue (
  input  logic                     clock,
  input  logic                     resetN,
  input  logic                     push,
  input  arrayOpsPkg::memResponseT pushData,
  output logic                     queueSpace,
  output logic                     respValid,
  output arrayOpsPkg::memResponseT resp,
  input  logic                     respReady
);
  import arrayOpsPkg::*;

  memResponseT entries [2];
  logic        wrPtr;
  logic        rdPtr;
  logic [1:0]  count;                            // Entries held, 0 to 2
  logic        popNow;

  assign queueSpace = (count != 2'd2);
  assign respValid  = (count != 2'd0);
  assign resp       = entries[rdPtr];
  assign popNow     = respValid && respReady;

  //----------------------------------------
  // Pointers and fill level
  //----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      wrPtr <= 1'b0;
      rdPtr <= 1'b0;
      count <= 2'd0;
    end else begin
      if (push) wrPtr <= !wrPtr;
      if (popNow) rdPtr <= !rdPtr;
      case ({push, popNow})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;             // Both or neither
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      entries[wrPtr] <= pushData;
    end
  end

endmodule

//--- tests/arrayMemoryModel.svh
//----------------------------------------
// Reference model: array bank state and
// expected response of each request
//----------------------------------------
`ifndef ARRAY_MEMORY_MODEL_SVH
`define ARRAY_MEMORY_MODEL_SVH

// State as it stands after reset
dataT     modelElems [arrayCount][arrayLength];
int       modelSizes [arrayCount];
bit       modelLive  [arrayCount];
arrayNumT modelFree  [$];                        // Newest release at the back
int       modelFresh;                            // Arrays never handed out

function automatic memResponseT expectedResponse(input memRequestT r);
  memResponseT rsp;
  int          a;
  int          i;
  dataT        old;
  dataT        upd;
  rsp.result = '0;
  rsp.error  = noError;
  a          = int'(r.array);
  i          = int'(r.index);
  old        = modelElems[a][i];
  if (r.opcode == alloc) begin
    if (modelFree.size() == 0 && modelFresh == arrayCount) begin
      rsp.error = noFreeArray;
    end else begin
      if (modelFree.size() != 0) begin
        a = int'(modelFree.pop_back());          // Reuse before fresh
      end else begin
        a = modelFresh;
        modelFresh++;
      end
      modelLive[a]  = 1'b1;
      modelSizes[a] = 0;
      rsp.result    = dataT'(a);
    end
  end else if (!modelLive[a]) begin
    rsp.error = notAllocated;
  end else begin
    case (r.opcode)
      releaseOp: begin
        modelLive[a] = 1'b0;
        modelFree.push_back(r.array);
      end
      write: begin
        modelElems[a][i] = r.operand;
        if (i >= modelSizes[a]) begin
          modelSizes[a] = i + 1;                 // Write grows the array
        end
        rsp.result = r.operand;
      end
      size: rsp.result = dataT'(modelSizes[a]);
      push: begin
        if (modelSizes[a] == arrayLength) begin
          rsp.error = arrayFull;
        end else begin
          modelElems[a][modelSizes[a]] = r.operand;
          modelSizes[a]++;
          rsp.result = r.operand;
        end
      end
      pop: begin
        if (modelSizes[a] == 0) begin
          rsp.error = arrayEmpty;
        end else begin
          modelSizes[a]--;
          rsp.result = modelElems[a][modelSizes[a]];
        end
      end
      findIndex, countLess, countGreater: begin
        for (int j = 0; j < modelSizes[a]; j++) begin
          if (r.opcode == findIndex && modelElems[a][j] == r.operand) begin
            rsp.result = dataT'(j + 1);          // Last match counts
          end
          if (r.opcode == countLess && modelElems[a][j] < r.operand) begin
            rsp.result = rsp.result + 1'b1;
          end
          if (r.opcode == countGreater && modelElems[a][j] > r.operand) begin
            rsp.result = rsp.result + 1'b1;
          end
        end
      end
      default: begin                             // Read and the updates
        if (i >= modelSizes[a]) begin
          rsp.error = outOfBounds;
        end else if (r.opcode == read) begin
          rsp.result = old;
        end else begin
          case (r.opcode)
            add, addAfter:      upd = old + r.operand;
            subtract, subAfter: upd = old - r.operand;
            andOp:              upd = old & r.operand;
            orOp:               upd = old | r.operand;
            default:            upd = old ^ r.operand;
          endcase
          modelElems[a][i] = upd;
          rsp.result = (r.opcode == addAfter || r.opcode == subAfter) ? old : upd;
        end
      end
    endcase
  end
  return rsp;
endfunction

`endif

//--- tests/arrayMemoryTb.sv
//----------------------------------------
// Testbench of the array memory unit:
// stimulus, checker, watchdog, report
//----------------------------------------
module arrayMemoryTb;
  import arrayGeometryPkg::*;
  import arrayOpsPkg::*;

  localparam int resetCycles = 8;
  localparam int readCount   = 40;
  localparam int searchCount = 48;
  localparam int updateCount = 60;
  localparam int stressCount = 200;
  // 190 directed requests plus the random ones
  localparam int totalRequests = 190 + readCount + searchCount + updateCount + stressCount;

  logic        clock;
  logic        resetN;
  logic        reqValid;
  logic        reqReady;
  memRequestT  req;
  logic        respValid;
  memResponseT resp;
  logic        respReady;

  memResponseT expectQ [$];                      // Expected responses, oldest first
  memResponseT expectedResp;
  string       testName;
  int          passCount;
  int          errorCount;                       // Response mismatches
  int          flowErrors;                       // Handshake problems
  int          errorsBefore;
  bit          randomReady;
  bit          sawStall;

  opcodeT searchOps [3] = '{findIndex, countLess, countGreater};
  opcodeT updateOps [7] = '{add, addAfter, subtract, subAfter, andOp, orOp, xorOp};
  opcodeT mixedOps [10] = '{write, read, size, push, pop, findIndex, countLess, add,
                            subAfter, xorOp};

  `include "arrayMemoryModel.svh"

  arrayMemory i_arrayMemory (
    .clock, .resetN, .reqValid, .reqReady, .req, .respValid, .resp, .respReady
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Ready stays high except in the back-pressure test
  initial begin
    respReady = 1'b0;
    forever begin
      @(negedge clock);
      respReady = randomReady ? ($urandom % 2 == 1) : 1'b1;
    end
  end

  function automatic int randomBelow(input int n);
    return int'($urandom % n);
  endfunction

  task automatic sendRequest(input opcodeT op, input int arr, input int idx, input dataT operand);
    memRequestT r;
    r.opcode  = op;
    r.array   = arrayNumT'(arr);
    r.index   = elemIndexT'(idx);
    r.operand = operand;
    req       = r;
    reqValid  = 1'b1;
    expectQ.push_back(expectedResponse(r));
    while (!reqReady) begin
      sawStall = 1'b1;
      @(negedge clock);
    end
    @(negedge clock);                            // Transfer at the rising edge
    reqValid = 1'b0;
  endtask

  task automatic finishTest();
    int errorsNow;
    while (expectQ.size() != 0) @(negedge clock);
    errorsNow = errorCount + flowErrors;
    $display("%s: %s with %0d errors", testName,
             (errorsNow == errorsBefore) ? "passed" : "failed", errorsNow - errorsBefore);
    errorsBefore = errorsNow;
  endtask

  //----------------------------------------
  // Response checker
  //----------------------------------------
  always @(posedge clock) begin
    if (resetN && respValid && respReady) begin
      assert (expectQ.size() != 0) else begin
        $display("%s: a response arrived with no request outstanding", testName);
        errorCount++;
      end
      if (expectQ.size() != 0) begin
        expectedResp = expectQ.pop_front();
        assert (resp == expectedResp) begin
          passCount++;
        end else begin
          $display("Error in %s: expected %h %s, actual %h %s", testName,
                   expectedResp.result, expectedResp.error.name(),
                   resp.result, resp.error.name());
          errorCount++;
        end
      end
    end
  end

  // Watchdog
  initial begin
    repeat (resetCycles + totalRequests * 20) @(posedge clock);
    $display("The run did not finish in time, responses are missing or stuck");
    $display("TEST FAILED");
    $finish;
  end

  //----------------------------------------
  // Stimulus
  //----------------------------------------
  initial begin
    void'($urandom(32'h83d1));
    resetN   = 1'b0;
    reqValid = 1'b0;
    req      = '0;
    repeat (resetCycles) @(negedge clock);
    resetN = 1'b1;

    testName = "allocation";
    for (int n = 0; n <= arrayCount; n++) sendRequest(alloc, 0, 0, '0);
    sendRequest(releaseOp, 3, 0, '0);
    sendRequest(releaseOp, 5, 0, '0);
    sendRequest(alloc, 0, 0, '0);                // Newest release first
    sendRequest(alloc, 0, 0, '0);
    sendRequest(releaseOp, 6, 0, '0);
    sendRequest(releaseOp, 6, 0, '0);            // Already released
    sendRequest(alloc, 0, 0, '0);
    finishTest();

    testName = "elements";
    for (int a = 0; a < arrayCount; a++) begin
      sendRequest(write, a, randomBelow(arrayLength), dataT'($urandom));
      sendRequest(write, a, randomBelow(arrayLength), dataT'($urandom));
      sendRequest(size, a, 0, '0);
    end
    for (int a = 0; a < arrayCount; a++) begin
      for (int i = 0; i < arrayLength; i++) sendRequest(write, a, i, dataT'($urandom));
    end
    for (int n = 0; n < readCount; n++) begin
      sendRequest(read, randomBelow(arrayCount), randomBelow(arrayLength), '0);
    end
    sendRequest(releaseOp, 7, 0, '0);
    sendRequest(read, 7, 0, '0);                 // Not live
    sendRequest(alloc, 0, 0, '0);
    sendRequest(read, 7, 0, '0);                 // Size is zero again
    finishTest();

    testName = "stack";
    for (int n = 0; n <= arrayLength; n++) sendRequest(push, 7, 0, dataT'($urandom));
    for (int n = 0; n <= arrayLength; n++) sendRequest(pop, 7, 0, '0);
    finishTest();

    testName = "searches";
    for (int a = 0; a < arrayCount; a++) begin
      for (int i = 0; i < arrayLength; i++) sendRequest(write, a, i, dataT'(randomBelow(8)));
    end
    for (int n = 0; n < searchCount; n++) begin
      sendRequest(searchOps[randomBelow(3)], randomBelow(arrayCount), 0, dataT'(randomBelow(8)));
    end
    finishTest();

    testName = "updates";
    for (int n = 0; n < updateCount; n++) begin
      sendRequest(updateOps[randomBelow(7)], randomBelow(arrayCount),
                  randomBelow(arrayLength), dataT'($urandom));
    end
    finishTest();

    testName    = "back-pressure";
    randomReady = 1'b1;
    sawStall    = 1'b0;
    for (int n = 0; n < stressCount; n++) begin
      sendRequest(mixedOps[randomBelow(10)], randomBelow(arrayCount),
                  randomBelow(arrayLength), dataT'($urandom));
    end
    assert (sawStall) else begin
      $display("%s: reqReady never fell while responses were held back", testName);
      flowErrors++;
    end
    finishTest();
    randomReady = 1'b0;

    $display("Checks passed: %0d, failed: %0d", passCount, errorCount + flowErrors);
    if (errorCount + flowErrors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
